// File: raster_top.f
+incdir+logic
logic/raster_pkg.sv
logic/raster_regs.sv
logic/triangle_setup.sv
logic/raster_scan.sv
logic/pixel_fifo.sv
logic/raster_top.sv
testbench/raster_tb.sv

// File: Makefile
# Verilator build and run for the triangle rasterizer
VERILATOR ?= verilator
TOP       ?= raster_tb
DUT_TOP   ?= raster_top
FILELIST  ?= raster_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/raster_tb.sv
`timescale 1ns/10ps
`include "raster_params.svh"

module raster_tb;
    import raster_pkg::*;

    localparam logic [31:0] lfsr_seed = 32'h5f20_0d70;
    localparam logic [31:0] vertex_mask = (32'd1 << (`COL_BITS + `ROW_BITS)) - 32'd1;
    localparam logic [31:0] color_mask = (32'd1 << $bits(color_t)) - 32'd1;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  psel = 1'b0;
    logic                  penable = 1'b0;
    logic                  pwrite = 1'b0;
    logic [`ADDR_BITS-1:0] paddr = '0;
    logic [31:0]           pwdata = '0;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pix_valid;
    logic                  pix_ready = 1'b1;
    pixel_t                pix;

    pixel_t      expected [$];
    pixel_t      want;
    logic [31:0] vert_state = lfsr_seed;
    logic [31:0] ready_state = lfsr_seed;
    bit          random_ready = 1'b0;
    int          errors = 0;
    int          received = 0;
    int          modeled = 0;
    int          cycles = 0;
    int          limit = 2000;

    raster_top i_raster_top (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix       (pix)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            vert_state = lfsr_step(vert_state);
            value = (value << 1) | int'(vert_state[0]);
        end
        return value;
    endfunction

    function automatic vertex_t make_vertex(input int x, input int y);
        vertex_t v;
        v.x = x[`COL_BITS-1:0];
        v.y = y[`ROW_BITS-1:0];
        return v;
    endfunction

    //////////////////////////////////////////////////
    // APB master
    //////////////////////////////////////////////////

    task automatic apb_write(input logic [`ADDR_BITS-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [`ADDR_BITS-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_readback(input logic [`ADDR_BITS-1:0] addr, input logic [31:0] value,
                                  input logic [31:0] mask, input string name);
        logic [31:0] data;
        apb_write(addr, value);
        apb_read(addr, data);
        assert (data == (value & mask))
        else
        begin
            errors++;
            $display("Error: %s got %h expected %h", name, data, value & mask);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference rasterizer
    //////////////////////////////////////////////////

    task automatic model_triangle(input triangle_t t);
        int     vx [3];
        int     vy [3];
        int     lx;
        int     hx;
        int     ly;
        int     hy;
        int     e;
        int     pos;
        int     neg;
        pixel_t p;
        vx[0] = int'(t.v0.x);
        vx[1] = int'(t.v1.x);
        vx[2] = int'(t.v2.x);
        vy[0] = int'(t.v0.y);
        vy[1] = int'(t.v1.y);
        vy[2] = int'(t.v2.y);
        lx = vx[0];
        hx = vx[0];
        ly = vy[0];
        hy = vy[0];
        for (int i = 1; i < 3; i++)
        begin
            lx = (vx[i] < lx) ? vx[i] : lx;
            hx = (vx[i] > hx) ? vx[i] : hx;
            ly = (vy[i] < ly) ? vy[i] : ly;
            hy = (vy[i] > hy) ? vy[i] : hy;
        end
        limit += 40 * (hx - lx + 1) * (hy - ly + 1);
        for (int y = ly; y <= hy; y++)
        begin
            for (int x = lx; x <= hx; x++)
            begin
                pos = 0;
                neg = 0;
                // Edge i runs from vertex i to vertex i+1
                for (int i = 0; i < 3; i++)
                begin
                    e = (x - vx[i]) * (vy[(i + 1) % 3] - vy[i])
                        - (y - vy[i]) * (vx[(i + 1) % 3] - vx[i]);
                    pos += (e >= 0) ? 1 : 0;
                    neg += (e <= 0) ? 1 : 0;
                end
                if (pos == 3 || neg == 3)
                begin
                    p = '0;
                    p.x = x[`COL_BITS-1:0];
                    p.y = y[`ROW_BITS-1:0];
                    p.color = t.color;
                    expected.push_back(p);
                    modeled++;
                end
            end
        end
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        status = 32'h1;
        while (status[0])
            apb_read(`REG_STATUS, status);
    endtask

    // Program, start, optionally poke CTRL while busy, then wait for idle
    task automatic draw_triangle(input triangle_t t, input bit poke);
        logic [31:0] status;
        model_triangle(t);
        apb_write(`REG_V0, 32'(t.v0));
        apb_write(`REG_V1, 32'(t.v1));
        apb_write(`REG_V2, 32'(t.v2));
        apb_write(`REG_COLOR, 32'(t.color));
        apb_write(`REG_CTRL, 32'h1);
        apb_read(`REG_STATUS, status);
        assert (status[0])
        else
        begin
            errors++;
            $display("Error: busy got %h expected %h", status[0], 1'b1);
        end
        if (poke)
        begin
            apb_write(`REG_CTRL, 32'h3);
            apb_write(`REG_CTRL, 32'h2);
        end
        wait_idle();
    endtask

    //////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) psel |-> pready)
    else
    begin
        errors++;
        $display("Error: pready got %h expected %h", pready, 1'b1);
    end

    assert property (@(posedge clk) disable iff (rst)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix))
    else
    begin
        errors++;
        $display("Stalled word on pix was dropped or changed");
    end

    assert property (@(posedge clk) disable iff (rst)
        i_raster_top.cmd == cmd_start && !i_raster_top.busy |=> i_raster_top.busy)
    else
    begin
        errors++;
        $display("Busy did not rise the cycle after an accepted start");
    end

    // Stream monitor samples ahead of the transfer edge
    always @(negedge clk)
    begin
        if (!rst && pix_valid && pix_ready)
        begin
            received++;
            assert (expected.size() != 0)
            else
            begin
                errors++;
                $display("Unexpected extra word on the pixel stream: %h", pix);
            end
            if (expected.size() != 0)
            begin
                want = expected.pop_front();
                assert (pix == want)
                else
                begin
                    errors++;
                    $display("Error: pix got %h expected %h", pix, want);
                end
            end
        end
    end

    always @(posedge clk)
    begin
        if (random_ready)
        begin
            ready_state = lfsr_step(ready_state);
            pix_ready <= ready_state[0];
        end
        else
            pix_ready <= 1'b1;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("Timeout after %0d cycles, %0d words still expected",
                     cycles, expected.size());
            $display("Some tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial
    begin
        triangle_t   t;
        vertex_t     tmp;
        pixel_t      eof_word;
        logic [31:0] data;
        int          bx;
        int          by;
        int          area;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!pix_valid && !i_raster_top.busy && !i_raster_top.push
                && !i_raster_top.setup_done)
        else
        begin
            errors++;
            $display("Outputs not idle after reset");
        end

        apb_read(`REG_STATUS, data);
        assert (data == 32'h0)
        else
        begin
            errors++;
            $display("Error: status got %h expected %h", data, 32'h0);
        end
        check_readback(`REG_V0, 32'hfff8_1234, vertex_mask, "v0");
        check_readback(`REG_V1, 32'h1237_abcd, vertex_mask, "v1");
        check_readback(`REG_V2, 32'h8005_5aa5, vertex_mask, "v2");
        check_readback(`REG_COLOR, 32'hcafe_f00d, color_mask, "color");

        // Right triangle in a 16 by 16 box
        t.v0 = make_vertex(40, 30);
        t.v1 = make_vertex(40, 45);
        t.v2 = make_vertex(55, 30);
        t.color = 18'h2a5c3;
        draw_triangle(t, 1'b0);

        for (int n = 0; n < 10; n++)
        begin
            if (n == 5)
                random_ready <= 1'b1;
            bx = rand_bits(9);
            by = rand_bits(8);
            t.v0 = rand_vertex(bx, by);
            t.v1 = rand_vertex(bx, by);
            t.v2 = rand_vertex(bx, by);
            data = 32'(rand_bits(18));
            t.color = data[17:0];
            // Alternate winding from one triangle to the next
            area = (int'(t.v1.x) - int'(t.v0.x)) * (int'(t.v2.y) - int'(t.v0.y))
                   - (int'(t.v1.y) - int'(t.v0.y)) * (int'(t.v2.x) - int'(t.v0.x));
            if ((n % 2 == 0) != (area >= 0))
            begin
                tmp = t.v1;
                t.v1 = t.v2;
                t.v2 = tmp;
            end
            draw_triangle(t, 1'b0);
        end

        // Degenerate line
        t.v0 = make_vertex(100, 50);
        t.v1 = make_vertex(104, 52);
        t.v2 = make_vertex(108, 54);
        t.color = 18'h0ff00;
        draw_triangle(t, 1'b0);

        // Start and flush while busy must not add words
        t.v0 = make_vertex(300, 200);
        t.v1 = make_vertex(315, 215);
        t.v2 = make_vertex(300, 215);
        t.color = 18'h3c0f3;
        draw_triangle(t, 1'b1);

        eof_word = '0;
        eof_word.eof = 1'b1;
        expected.push_back(eof_word);
        modeled++;
        apb_write(`REG_CTRL, 32'h2);
        wait_idle();

        while (expected.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);
        assert (received == modeled)
        else
        begin
            errors++;
            $display("Error: word count got %h expected %h", received, modeled);
        end

        $display("Words received %0d, expected %0d, errors %0d", received, modeled, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    function automatic vertex_t rand_vertex(input int bx, input int by);
        int x;
        int y;
        x = bx + rand_bits(4);
        y = by + rand_bits(4);
        return make_vertex(x, y);
    endfunction

endmodule

// File: logic/raster_top.sv
`timescale 1ns/10ps
`include "raster_params.svh"

module raster_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`ADDR_BITS-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output raster_pkg::pixel_t    pix
);
    import raster_pkg::*;

    triangle_t   triangle;
    raster_cmd_t cmd;
    logic        busy;
    logic        setup_go;
    logic        setup_done;
    setup_t      setup;
    logic        full;
    logic        push;
    pixel_t      push_data;

    raster_regs i_raster_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .busy     (busy),
        .triangle (triangle),
        .cmd      (cmd)
    );

    triangle_setup i_triangle_setup (
        .clk        (clk),
        .rst        (rst),
        .go         (setup_go),
        .triangle   (triangle),
        .setup_done (setup_done),
        .setup      (setup)
    );

    raster_scan i_raster_scan (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .setup_go   (setup_go),
        .setup_done (setup_done),
        .setup      (setup),
        .busy       (busy),
        .full       (full),
        .push       (push),
        .push_data  (push_data)
    );

    pixel_fifo i_pixel_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix       (pix)
    );

endmodule

// File: logic/pixel_fifo.sv
`timescale 1ns/10ps
`include "raster_params.svh"

module pixel_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  raster_pkg::pixel_t push_data,
    output logic               full,
    output logic               pix_valid,
    input  logic               pix_ready,
    output raster_pkg::pixel_t pix
);
    import raster_pkg::*;

    localparam int depth = `FIFO_DEPTH;
    localparam int ptr_bits = $clog2(depth);

    pixel_t              mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0]   count;
    logic                load;
    logic                pop;
    logic                bypass;
    logic                write;

    assign full = (count == depth[ptr_bits:0]);
    // Output register free or draining this cycle
    assign load = !pix_valid || pix_ready;
    assign pop = load && (count != '0);
    // Word goes straight to the output register when the buffer is empty
    assign bypass = load && (count == '0) && push;
    assign write = push && !full && !bypass;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            pix_valid <= 1'b0;
        end
        else
        begin
            if (write)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (write && !pop)
                count <= count + 1'b1;
            else if (pop && !write)
                count <= count - 1'b1;
            if (load)
                pix_valid <= pop || bypass;
        end
    end

    always_ff @(posedge clk)
    begin
        if (write)
            mem[wr_ptr] <= push_data;
        if (pop)
            pix <= mem[rd_ptr];
        else if (bypass)
            pix <= push_data;
    end

endmodule

// File: logic/raster_scan.sv
`timescale 1ns/10ps
`include "raster_params.svh"

module raster_scan (
    input  logic                    clk,
    input  logic                    rst,
    input  raster_pkg::raster_cmd_t cmd,
    output logic                    setup_go,
    input  logic                    setup_done,
    input  raster_pkg::setup_t      setup,
    output logic                    busy,
    input  logic                    full,
    output logic                    push,
    output raster_pkg::pixel_t      push_data
);
    import raster_pkg::*;

    scan_state_t                  state;
    setup_t                       box;
    logic [`COL_BITS-1:0]         cur_x;
    logic [`ROW_BITS-1:0]         cur_y;
    logic signed [`EDGE_BITS-1:0] row_e [3];
    logic signed [`EDGE_BITS-1:0] run_e [3];
    logic                         flush_pend;
    logic                         nonneg;
    logic                         nonpos;
    logic                         covered;
    logic                         stall;
    logic                         last_x;
    logic                         last_y;

    // Inside for either winding
    always_comb
    begin
        nonneg = 1'b1;
        nonpos = 1'b1;
        for (int i = 0; i < 3; i++)
        begin
            if (run_e[i] < 0)
                nonneg = 1'b0;
            if (run_e[i] > 0)
                nonpos = 1'b0;
        end
    end

    assign covered = nonneg || nonpos;
    assign stall = covered && full;
    assign last_x = (cur_x == box.max_x);
    assign last_y = (cur_y == box.max_y);

    assign busy = (state != scan_idle) || flush_pend;
    assign setup_go = (state == scan_idle) && !flush_pend && (cmd == cmd_start);

    //////////////////////////////////////////////////
    // FIFO write port
    //////////////////////////////////////////////////

    always_comb
    begin
        push = 1'b0;
        push_data = '0;
        if (state == scan_pixel)
        begin
            push = covered && !full;
            push_data.x = cur_x;
            push_data.y = cur_y;
            push_data.color = box.color;
        end
        else if (flush_pend)
        begin
            // End-of-frame marker with all other fields zero
            push = !full;
            push_data.eof = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Traversal FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= scan_idle;
            flush_pend <= 1'b0;
        end
        else
        begin
            case (state)
                scan_idle:
                begin
                    if (flush_pend)
                    begin
                        if (!full)
                            flush_pend <= 1'b0;
                    end
                    else if (cmd == cmd_start)
                        state <= scan_setup;
                    else if (cmd == cmd_flush)
                        flush_pend <= 1'b1;
                end
                scan_setup:
                begin
                    if (setup_done)
                        state <= scan_row;
                end
                scan_row:
                    state <= scan_pixel;
                scan_pixel:
                begin
                    if (!stall && last_x)
                        state <= last_y ? scan_idle : scan_row;
                end
                default:
                    state <= scan_idle;
            endcase
        end
    end

    // Coordinates and edge accumulators
    always_ff @(posedge clk)
    begin
        case (state)
            scan_setup:
            begin
                if (setup_done)
                begin
                    box <= setup;
                    cur_y <= setup.min_y;
                    for (int i = 0; i < 3; i++)
                        row_e[i] <= setup.edges[i].init;
                end
            end
            scan_row:
            begin
                cur_x <= box.min_x;
                for (int i = 0; i < 3; i++)
                begin
                    run_e[i] <= row_e[i];
                    row_e[i] <= row_e[i] + box.edges[i].step_y;
                end
            end
            scan_pixel:
            begin
                // Covered pixel waits for FIFO space
                if (!stall)
                begin
                    cur_x <= cur_x + 1'b1;
                    for (int i = 0; i < 3; i++)
                        run_e[i] <= run_e[i] + box.edges[i].step_x;
                    if (last_x)
                        cur_y <= cur_y + 1'b1;
                end
            end
            default:
            begin
            end
        endcase
    end

endmodule

// File: logic/triangle_setup.sv
`timescale 1ns/10ps
`include "raster_params.svh"

module triangle_setup (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  go,
    input  raster_pkg::triangle_t triangle,
    output logic                  setup_done,
    output raster_pkg::setup_t    setup
);
    import raster_pkg::*;

    logic [`COL_BITS-1:0]         vx [3];
    logic [`ROW_BITS-1:0]         vy [3];
    logic signed [`EDGE_BITS-1:0] wx [3];
    logic signed [`EDGE_BITS-1:0] wy [3];
    logic [`COL_BITS-1:0]         lo_x;
    logic [`COL_BITS-1:0]         hi_x;
    logic [`ROW_BITS-1:0]         lo_y;
    logic [`ROW_BITS-1:0]         hi_y;
    logic signed [`EDGE_BITS-1:0] wlo_x;
    logic signed [`EDGE_BITS-1:0] wlo_y;

    logic                         s1_valid;
    logic                         s2_valid;
    logic signed [`EDGE_BITS-1:0] s1_ox [3];
    logic signed [`EDGE_BITS-1:0] s1_oy [3];
    logic signed [`EDGE_BITS-1:0] s2_px [3];
    logic signed [`EDGE_BITS-1:0] s2_py [3];

    assign vx[0] = triangle.v0.x;
    assign vx[1] = triangle.v1.x;
    assign vx[2] = triangle.v2.x;
    assign vy[0] = triangle.v0.y;
    assign vy[1] = triangle.v1.y;
    assign vy[2] = triangle.v2.y;

    // Bounding box and zero-extended coordinates
    always_comb
    begin
        lo_x = vx[0];
        hi_x = vx[0];
        lo_y = vy[0];
        hi_y = vy[0];
        for (int i = 0; i < 3; i++)
        begin
            if (vx[i] < lo_x)
                lo_x = vx[i];
            if (vx[i] > hi_x)
                hi_x = vx[i];
            if (vy[i] < lo_y)
                lo_y = vy[i];
            if (vy[i] > hi_y)
                hi_y = vy[i];
            wx[i] = {{(`EDGE_BITS-`COL_BITS){1'b0}}, vx[i]};
            wy[i] = {{(`EDGE_BITS-`ROW_BITS){1'b0}}, vy[i]};
        end
        wlo_x = {{(`EDGE_BITS-`COL_BITS){1'b0}}, lo_x};
        wlo_y = {{(`EDGE_BITS-`ROW_BITS){1'b0}}, lo_y};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            setup_done <= 1'b0;
        end
        else
        begin
            s1_valid <= go;
            s2_valid <= s1_valid;
            setup_done <= s2_valid;
        end
    end

    //////////////////////////////////////////////////
    // Edge a to b is (x-xa)(yb-ya) - (y-ya)(xb-xa)
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (go)
        begin
            setup.min_x <= lo_x;
            setup.max_x <= hi_x;
            setup.min_y <= lo_y;
            setup.max_y <= hi_y;
            setup.color <= triangle.color;
        end
        for (int i = 0; i < 3; i++)
        begin
            if (go)
            begin
                setup.edges[i].step_x <= wy[(i + 1) % 3] - wy[i];
                // step_y is the negated x difference
                setup.edges[i].step_y <= wx[i] - wx[(i + 1) % 3];
                s1_ox[i] <= wlo_x - wx[i];
                s1_oy[i] <= wlo_y - wy[i];
            end
            if (s1_valid)
            begin
                s2_px[i] <= s1_ox[i] * setup.edges[i].step_x;
                s2_py[i] <= s1_oy[i] * setup.edges[i].step_y;
            end
            if (s2_valid)
                setup.edges[i].init <= s2_px[i] + s2_py[i];
        end
    end

endmodule

// File: logic/raster_regs.sv
`timescale 1ns/10ps
`include "raster_params.svh"

module raster_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`ADDR_BITS-1:0]   paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    input  logic                    busy,
    output raster_pkg::triangle_t   triangle,
    output raster_pkg::raster_cmd_t cmd
);
    import raster_pkg::*;

    localparam int vertex_bits = $bits(vertex_t);
    localparam int color_bits = $bits(color_t);

    logic wr_access;

    // No wait states
    assign pready = 1'b1;
    assign wr_access = psel && penable && pwrite;

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            triangle <= '0;
            cmd <= cmd_none;
        end
        else
        begin
            cmd <= cmd_none;
            if (wr_access)
            begin
                case (paddr)
                    `REG_CTRL:
                    begin
                        // Start wins over flush
                        if (pwdata[0])
                            cmd <= cmd_start;
                        else if (pwdata[1])
                            cmd <= cmd_flush;
                    end
                    `REG_V0:
                        triangle.v0 <= pwdata[vertex_bits-1:0];
                    `REG_V1:
                        triangle.v1 <= pwdata[vertex_bits-1:0];
                    `REG_V2:
                        triangle.v2 <= pwdata[vertex_bits-1:0];
                    `REG_COLOR:
                        triangle.color <= pwdata[color_bits-1:0];
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb
    begin
        case (paddr)
            `REG_STATUS:
                prdata = {31'b0, busy};
            `REG_V0:
                prdata = 32'(triangle.v0);
            `REG_V1:
                prdata = 32'(triangle.v1);
            `REG_V2:
                prdata = 32'(triangle.v2);
            `REG_COLOR:
                prdata = 32'(triangle.color);
            default:
                prdata = 32'b0;
        endcase
    end

endmodule

// File: logic/raster_pkg.sv
`include "raster_params.svh"

package raster_pkg;

    typedef struct packed {
        logic [`COL_BITS-1:0] x;
        logic [`ROW_BITS-1:0] y;
    } vertex_t;

    // RGB666
    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } color_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
        color_t  color;
    } triangle_t;

    // Edge value at the box origin and its increments
    typedef struct packed {
        logic signed [`EDGE_BITS-1:0] init;
        logic signed [`EDGE_BITS-1:0] step_x;
        logic signed [`EDGE_BITS-1:0] step_y;
    } edge_t;

    typedef struct packed {
        logic [`COL_BITS-1:0] min_x;
        logic [`COL_BITS-1:0] max_x;
        logic [`ROW_BITS-1:0] min_y;
        logic [`ROW_BITS-1:0] max_y;
        edge_t [2:0]          edges;
        color_t               color;
    } setup_t;

    typedef struct packed {
        logic                 eof;
        logic [`COL_BITS-1:0] x;
        logic [`ROW_BITS-1:0] y;
        color_t               color;
    } pixel_t;

    typedef enum logic [1:0] {
        scan_idle,
        scan_setup,
        scan_row,
        scan_pixel
    } scan_state_t;

    typedef enum logic [1:0] {
        cmd_none,
        cmd_start,
        cmd_flush
    } raster_cmd_t;

endpackage

// File: logic/raster_params.svh
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Screen coordinate widths
`define COL_BITS 10
`define ROW_BITS 9

// Signed edge function width
`define EDGE_BITS 24

`define FIFO_DEPTH 8

// APB register map
`define ADDR_BITS 8
`define REG_CTRL 8'h00
`define REG_STATUS 8'h04
`define REG_V0 8'h08
`define REG_V1 8'h0C
`define REG_V2 8'h10
`define REG_COLOR 8'h14

`endif
